/* Bender.yml */
package:
  name: axi_wb_bridge

sources:
  - include_dirs:
      - design
    files:
      - design/axi_lite_pkg.sv
      - design/wb_pkg.sv
      - design/axi_chan_slot.sv
      - design/axi_wb_sequencer.sv
      - design/axi_wb_bridge_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/tb_axi_wb_bridge.sv

/* design/axi_chan_slot.sv */
`default_nettype none

module axi_chan_slot #(
   parameter type payload_t = logic
) (
   input  logic     i_clk,
   input  logic     i_rst,
   // Upstream side
   input  logic     i_valid,
   input  payload_t i_data,
   output logic     o_ready,
   // Downstream side
   output logic     o_valid,
   output payload_t o_data,
   input  logic     i_ready
);

   logic     full;
   logic     live;
   payload_t data_q;

   // Holds readies low until the cycle after reset
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         live <= 1'b0;
         full <= 1'b0;
      end else begin
         live <= 1'b1;
         if (i_valid && o_ready) begin
            full <= 1'b1;
         end else if (full && i_ready) begin
            full <= 1'b0;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_valid && o_ready) begin
         data_q <= i_data;
      end
   end

   assign o_ready = live && !full;
   assign o_valid = full;
   assign o_data  = data_q;

   // Payload held while the consumer stalls
   a_hold_stable: assert property (@(posedge i_clk) disable iff (i_rst)
      o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

`default_nettype wire

/* design/axi_lite_pkg.sv */
`default_nettype none

`include "bridge_macros.svh"

package axi_lite_pkg;

   // Only OKAY and SLVERR are produced by the bridge
   typedef enum logic [1:0] {
      AXI_OKAY   = 2'b00,
      AXI_SLVERR = 2'b10
   } axi_resp_e;

   // AW and AR beats
   typedef struct packed {
      logic [`BRIDGE_ADDR_W-1:0] addr;
   } axi_addr_t;

   typedef struct packed {
      logic [`BRIDGE_DATA_W-1:0] data;
      logic [`BRIDGE_STRB_W-1:0] strb;
   } axi_w_t;

   typedef struct packed {
      axi_resp_e resp;
   } axi_b_t;

   typedef struct packed {
      logic [`BRIDGE_DATA_W-1:0] data;
      axi_resp_e                 resp;
   } axi_r_t;

endpackage

`default_nettype wire

/* design/axi_wb_bridge_top.sv */
`default_nettype none

module axi_wb_bridge_top (
   input  logic                    i_clk,
   input  logic                    i_rst,
   // AXI4-Lite slave
   input  logic                    i_awvalid,
   input  axi_lite_pkg::axi_addr_t i_aw,
   output logic                    o_awready,
   input  logic                    i_wvalid,
   input  axi_lite_pkg::axi_w_t    i_w,
   output logic                    o_wready,
   input  logic                    i_arvalid,
   input  axi_lite_pkg::axi_addr_t i_ar,
   output logic                    o_arready,
   output logic                    o_bvalid,
   output axi_lite_pkg::axi_b_t    o_b,
   input  logic                    i_bready,
   output logic                    o_rvalid,
   output axi_lite_pkg::axi_r_t    o_r,
   input  logic                    i_rready,
   // Wishbone master
   output wb_pkg::wb_req_t         o_wb_req,
   input  wb_pkg::wb_rsp_t         i_wb_rsp
);

   // Slot to sequencer links
   logic aw_valid, w_valid, ar_valid;
   logic aw_pop, w_pop, ar_pop;
   logic b_push, r_push;
   logic b_empty, r_empty;

   axi_lite_pkg::axi_addr_t aw_q;
   axi_lite_pkg::axi_w_t    w_q;
   axi_lite_pkg::axi_addr_t ar_q;
   axi_lite_pkg::axi_b_t    b_d;
   axi_lite_pkg::axi_r_t    r_d;

   axi_chan_slot #(.payload_t(axi_lite_pkg::axi_addr_t)) aw_slot (
      .i_clk, .i_rst,
      .i_valid(i_awvalid), .i_data(i_aw), .o_ready(o_awready),
      .o_valid(aw_valid), .o_data(aw_q), .i_ready(aw_pop)
   );

   axi_chan_slot #(.payload_t(axi_lite_pkg::axi_w_t)) w_slot (
      .i_clk, .i_rst,
      .i_valid(i_wvalid), .i_data(i_w), .o_ready(o_wready),
      .o_valid(w_valid), .o_data(w_q), .i_ready(w_pop)
   );

   axi_chan_slot #(.payload_t(axi_lite_pkg::axi_addr_t)) ar_slot (
      .i_clk, .i_rst,
      .i_valid(i_arvalid), .i_data(i_ar), .o_ready(o_arready),
      .o_valid(ar_valid), .o_data(ar_q), .i_ready(ar_pop)
   );

   axi_chan_slot #(.payload_t(axi_lite_pkg::axi_b_t)) b_slot (
      .i_clk, .i_rst,
      .i_valid(b_push), .i_data(b_d), .o_ready(b_empty),
      .o_valid(o_bvalid), .o_data(o_b), .i_ready(i_bready)
   );

   axi_chan_slot #(.payload_t(axi_lite_pkg::axi_r_t)) r_slot (
      .i_clk, .i_rst,
      .i_valid(r_push), .i_data(r_d), .o_ready(r_empty),
      .o_valid(o_rvalid), .o_data(o_r), .i_ready(i_rready)
   );

   axi_wb_sequencer seq (
      .i_clk, .i_rst,
      .i_aw_valid(aw_valid), .i_aw(aw_q), .o_aw_ready(aw_pop),
      .i_w_valid(w_valid), .i_w(w_q), .o_w_ready(w_pop),
      .i_ar_valid(ar_valid), .i_ar(ar_q), .o_ar_ready(ar_pop),
      .o_b_valid(b_push), .o_b(b_d), .i_b_ready(b_empty),
      .o_r_valid(r_push), .o_r(r_d), .i_r_ready(r_empty),
      .o_wb_req, .i_wb_rsp
   );

endmodule

`default_nettype wire

/* design/axi_wb_sequencer.sv */
`default_nettype none

`include "bridge_macros.svh"

module axi_wb_sequencer (
   input  logic                  i_clk,
   input  logic                  i_rst,
   // Inbound slots
   input  logic                  i_aw_valid,
   input  axi_lite_pkg::axi_addr_t i_aw,
   output logic                  o_aw_ready,
   input  logic                  i_w_valid,
   input  axi_lite_pkg::axi_w_t  i_w,
   output logic                  o_w_ready,
   input  logic                  i_ar_valid,
   input  axi_lite_pkg::axi_addr_t i_ar,
   output logic                  o_ar_ready,
   // Outbound slots, ready means empty
   output logic                  o_b_valid,
   output axi_lite_pkg::axi_b_t  o_b,
   input  logic                  i_b_ready,
   output logic                  o_r_valid,
   output axi_lite_pkg::axi_r_t  o_r,
   input  logic                  i_r_ready,
   // Wishbone master
   output wb_pkg::wb_req_t       o_wb_req,
   input  wb_pkg::wb_rsp_t       i_wb_rsp
);

   typedef enum logic [1:0] {
      IDLE,
      WB_WRITE,
      WB_READ
   } state_e;

   state_e state;
   logic   wr_prio;

   logic wr_elig;
   logic rd_elig;
   logic grant_wr;
   logic grant_rd;
   logic wb_done;

   logic [`BRIDGE_ADDR_W-`BRIDGE_WORD_LSB-1:0] req_adr;
   logic [`BRIDGE_DATA_W-1:0]                  req_dat;
   logic [`BRIDGE_STRB_W-1:0]                  req_sel;
   logic                                       req_we;
   logic                                       req_stb;

   axi_lite_pkg::axi_resp_e resp;

   // A request is eligible only if its response has somewhere to go
   assign wr_elig = i_aw_valid && i_w_valid && i_b_ready;
   assign rd_elig = i_ar_valid && i_r_ready;

   assign grant_wr = (state == IDLE) && wr_elig && (!rd_elig || wr_prio);
   assign grant_rd = (state == IDLE) && rd_elig && !grant_wr;

   // Pop the inbound slots on the grant edge
   assign o_aw_ready = grant_wr;
   assign o_w_ready  = grant_wr;
   assign o_ar_ready = grant_rd;

   assign wb_done = i_wb_rsp.ack || i_wb_rsp.err;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state   <= IDLE;
         wr_prio <= 1'b1;
         req_stb <= 1'b0;
         req_we  <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (grant_wr) begin
                  state   <= WB_WRITE;
                  req_stb <= 1'b1;
                  req_we  <= 1'b1;
               end else if (grant_rd) begin
                  state   <= WB_READ;
                  req_stb <= 1'b1;
                  req_we  <= 1'b0;
               end
               // Alternate only when both kinds competed
               if (wr_elig && rd_elig) begin
                  wr_prio <= !wr_prio;
               end
            end
            WB_WRITE, WB_READ: begin
               if (wb_done) begin
                  state   <= IDLE;
                  req_stb <= 1'b0;
                  req_we  <= 1'b0;
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // Request payload, loaded at grant
   always_ff @(posedge i_clk) begin
      if (grant_wr) begin
         req_adr <= i_aw.addr[`BRIDGE_ADDR_W-1:`BRIDGE_WORD_LSB];
         req_dat <= i_w.data;
         req_sel <= i_w.strb;
      end else if (grant_rd) begin
         req_adr <= i_ar.addr[`BRIDGE_ADDR_W-1:`BRIDGE_WORD_LSB];
         req_sel <= `BRIDGE_READ_SEL;
      end
   end

   assign o_wb_req.adr = req_adr;
   assign o_wb_req.dat = req_dat;
   assign o_wb_req.sel = req_sel;
   assign o_wb_req.we  = req_we;
   assign o_wb_req.stb = req_stb;

   // err wins over ack
   assign resp = i_wb_rsp.err ? axi_lite_pkg::AXI_SLVERR : axi_lite_pkg::AXI_OKAY;

   // Response pushed on the edge that samples ack or err
   assign o_b_valid = (state == WB_WRITE) && wb_done;
   assign o_b.resp  = resp;
   assign o_r_valid = (state == WB_READ) && wb_done;
   assign o_r.data  = i_wb_rsp.dat;
   assign o_r.resp  = resp;

   a_req_stable: assert property (@(posedge i_clk) disable iff (i_rst)
      req_stb && !wb_done |=> req_stb && $stable(o_wb_req));

   a_ack_err_excl: assert property (@(posedge i_clk) disable iff (i_rst)
      req_stb |-> !(i_wb_rsp.ack && i_wb_rsp.err));

endmodule

`default_nettype wire

/* design/bridge_macros.svh */
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// AXI byte address width
`define BRIDGE_ADDR_W 12

// Data bus width
`define BRIDGE_DATA_W 32

// One strobe bit per data byte
`define BRIDGE_STRB_W 4

// Low address bits dropped for Wishbone word addressing
`define BRIDGE_WORD_LSB 2

// Reads always fetch the whole word
`define BRIDGE_READ_SEL {`BRIDGE_STRB_W{1'b1}}

`endif

/* design/wb_pkg.sv */
`default_nettype none

`include "bridge_macros.svh"

package wb_pkg;

   // Master side of one classic Wishbone cycle
   typedef struct packed {
      logic [`BRIDGE_ADDR_W-`BRIDGE_WORD_LSB-1:0] adr;
      logic [`BRIDGE_DATA_W-1:0]                  dat;
      logic [`BRIDGE_STRB_W-1:0]                  sel;
      logic                                       we;
      logic                                       stb;
   } wb_req_t;

   // Slave answer, ack or err ends the cycle
   typedef struct packed {
      logic [`BRIDGE_DATA_W-1:0] dat;
      logic                      ack;
      logic                      err;
   } wb_rsp_t;

endpackage

`default_nettype wire

/* dv/tb_axi_wb_bridge.sv */
`default_nettype none

`include "bridge_macros.svh"

module tb_axi_wb_bridge;

   localparam int ADDR_W    = `BRIDGE_ADDR_W;
   localparam int LSB       = `BRIDGE_WORD_LSB;
   localparam int WA_W      = ADDR_W - LSB;
   localparam int N_CONC    = 8;
   localparam int N_TXN     = 48;
   localparam int RESET_CYC = 16;

   logic                    i_clk, i_rst;
   logic                    i_awvalid, i_wvalid, i_arvalid, i_bready, i_rready;
   logic                    o_awready, o_wready, o_arready, o_bvalid, o_rvalid;
   axi_lite_pkg::axi_addr_t i_aw, i_ar;
   axi_lite_pkg::axi_w_t    i_w;
   axi_lite_pkg::axi_b_t    o_b, b_held;
   axi_lite_pkg::axi_r_t    o_r, r_held;
   wb_pkg::wb_req_t         o_wb_req;
   wb_pkg::wb_rsp_t         i_wb_rsp;

   logic [`BRIDGE_DATA_W-1:0] mem [1 << WA_W];
   logic [`BRIDGE_DATA_W-1:0] shadow [1 << WA_W];
   logic [15:0] lfsr_q;
   logic [1:0]  wb_wait;
   logic        bp_en, b_held_vld, r_held_vld;
   int          b_errs, r_errs, sig_errs, other_errs;

   axi_lite_pkg::axi_b_t exp_b_q [$];
   axi_lite_pkg::axi_r_t exp_r_q [$];

   axi_wb_bridge_top uut (.*);

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;
   end

   // Fibonacci LFSR with taps 16 14 13 11
   // One step per random bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
         r = {r[30:0], lfsr_q[0]};
      end
      return r;
   endfunction

   // Region sits in the top two address bits
   // Regions 2'b1x form the error region
   function automatic axi_lite_pkg::axi_addr_t rand_addr(input logic [1:0] region);
      axi_lite_pkg::axi_addr_t a;
      logic [31:0] r;
      r = rand_bits(ADDR_W - 2);
      a.addr = {region, r[ADDR_W-3:0]};
      return a;
   endfunction

   function automatic logic [31:0] fill_word(input logic [WA_W-1:0] a);
      return {6'h2b, a, 6'h15, ~a};
   endfunction

   function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] d,
                                         input logic [3:0] s);
      logic [31:0] r;
      r = old;
      for (int k = 0; k < `BRIDGE_STRB_W; k++) begin
         if (s[k]) r[8*k +: 8] = d[8*k +: 8];
      end
      return r;
   endfunction

   // Expected read beat from the shadow memory
   function automatic axi_lite_pkg::axi_r_t exp_read(input axi_lite_pkg::axi_addr_t a);
      axi_lite_pkg::axi_r_t r;
      r.data = shadow[a.addr[ADDR_W-1:LSB]];
      r.resp = a.addr[ADDR_W-1] ? axi_lite_pkg::AXI_SLVERR : axi_lite_pkg::AXI_OKAY;
      return r;
   endfunction

   task automatic check_b(input string name, input axi_lite_pkg::axi_b_t got,
                          input axi_lite_pkg::axi_b_t exp);
      if (got !== exp) begin
         b_errs++;
         $display("[ERROR] %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_r(input string name, input axi_lite_pkg::axi_r_t got,
                          input axi_lite_pkg::axi_r_t exp);
      if (got !== exp) begin
         r_errs++;
         $display("[ERROR] %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         sig_errs++;
         $display("[ERROR] %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic send_aw(input axi_lite_pkg::axi_addr_t a, input int dly);
      repeat (dly) @(posedge i_clk);
      @(posedge i_clk);
      i_awvalid <= 1'b1;
      i_aw      <= a;
      do @(negedge i_clk); while (!o_awready);
      @(posedge i_clk);
      i_awvalid <= 1'b0;
   endtask

   task automatic send_w(input axi_lite_pkg::axi_w_t w, input int dly);
      repeat (dly) @(posedge i_clk);
      @(posedge i_clk);
      i_wvalid <= 1'b1;
      i_w      <= w;
      do @(negedge i_clk); while (!o_wready);
      @(posedge i_clk);
      i_wvalid <= 1'b0;
   endtask

   task automatic send_ar(input axi_lite_pkg::axi_addr_t a, input int dly);
      repeat (dly) @(posedge i_clk);
      @(posedge i_clk);
      i_arvalid <= 1'b1;
      i_ar      <= a;
      do @(negedge i_clk); while (!o_arready);
      @(posedge i_clk);
      i_arvalid <= 1'b0;
   endtask

   task automatic do_write(input axi_lite_pkg::axi_addr_t a, input logic [31:0] d,
                           input logic [3:0] s, input int aw_dly, input int w_dly);
      axi_lite_pkg::axi_w_t w;
      axi_lite_pkg::axi_b_t b;
      axi_lite_pkg::axi_r_t r;
      w.data = d;
      w.strb = s;
      r = exp_read(a);
      b.resp = r.resp;
      if (!a.addr[ADDR_W-1]) begin
         shadow[a.addr[ADDR_W-1:LSB]] = merge(shadow[a.addr[ADDR_W-1:LSB]], d, s);
      end
      exp_b_q.push_back(b);
      fork
         send_aw(a, aw_dly);
         send_w(w, w_dly);
      join
   endtask

   task automatic do_read(input axi_lite_pkg::axi_addr_t a, input int dly);
      exp_r_q.push_back(exp_read(a));
      send_ar(a, dly);
   endtask

   task automatic wait_idle();
      while (exp_b_q.size() != 0 || exp_r_q.size() != 0) @(posedge i_clk);
   endtask

   task automatic write_then_read(input axi_lite_pkg::axi_addr_t a, input int aw_dly,
                                  input int w_dly);
      do_write(a, rand_bits(32), 4'(rand_bits(4)), aw_dly, w_dly);
      wait_idle();
      do_read(a, 0);
      wait_idle();
   endtask

   // Wishbone memory with 0 to 3 wait cycles
   // The upper half answers with err
   // Unselected byte lanes read as zero
   always @(posedge i_clk) begin
      if (i_rst) begin
         i_wb_rsp <= '0;
         wb_wait  <= '0;
      end else if (i_wb_rsp.ack || i_wb_rsp.err) begin
         i_wb_rsp <= '0;
      end else if (o_wb_req.stb) begin
         if (wb_wait == 0) begin
            wb_wait      <= 2'(rand_bits(2));
            i_wb_rsp.dat <= merge('0, mem[o_wb_req.adr], o_wb_req.sel);
            i_wb_rsp.err <= o_wb_req.adr[WA_W-1];
            i_wb_rsp.ack <= !o_wb_req.adr[WA_W-1];
            if (o_wb_req.we && !o_wb_req.adr[WA_W-1]) begin
               mem[o_wb_req.adr] <= merge(mem[o_wb_req.adr], o_wb_req.dat, o_wb_req.sel);
            end
         end else begin
            wb_wait <= wb_wait - 2'd1;
         end
      end
   end

   always @(posedge i_clk) begin
      i_bready <= bp_en ? (rand_bits(2) == 3) : 1'b1;
      i_rready <= bp_en ? (rand_bits(2) == 3) : 1'b1;
   end

   // Response compare on the falling edge
   // A handshake follows at the next rising edge
   always @(negedge i_clk) begin
      if (!i_rst) begin
         if (o_bvalid) begin
            if (b_held_vld) check_b("o_b hold", o_b, b_held);
            b_held     = o_b;
            b_held_vld = !i_bready;
            if (i_bready && exp_b_q.size() == 0) begin
               other_errs++;
               $display("B response arrived with no write outstanding");
            end else if (i_bready) begin
               check_b("o_b", o_b, exp_b_q.pop_front());
            end
         end else if (b_held_vld) begin
            other_errs++;
            b_held_vld = 1'b0;
            $display("B valid dropped before it was accepted");
         end
         if (o_rvalid) begin
            if (r_held_vld) check_r("o_r hold", o_r, r_held);
            r_held     = o_r;
            r_held_vld = !i_rready;
            if (i_rready && exp_r_q.size() == 0) begin
               other_errs++;
               $display("R response arrived with no read outstanding");
            end else if (i_rready) begin
               check_r("o_r", o_r, exp_r_q.pop_front());
            end
         end else if (r_held_vld) begin
            other_errs++;
            r_held_vld = 1'b0;
            $display("R valid dropped before it was accepted");
         end
      end
   end

   initial begin
      repeat (RESET_CYC + N_TXN * 40) @(posedge i_clk);
      $display("Timeout with %0d B and %0d R responses outstanding",
               exp_b_q.size(), exp_r_q.size());
      $display("TB FAILED");
      $finish;
   end

   initial begin
      lfsr_q     = 16'd44;
      i_rst      = 1'b1;
      i_awvalid  = 1'b0;
      i_wvalid   = 1'b0;
      i_arvalid  = 1'b0;
      i_aw       = '0;
      i_w        = '0;
      i_ar       = '0;
      i_bready   = 1'b1;
      i_rready   = 1'b1;
      i_wb_rsp   = '0;
      bp_en      = 1'b0;
      b_held_vld = 1'b0;
      r_held_vld = 1'b0;
      b_errs     = 0;
      r_errs     = 0;
      sig_errs   = 0;
      other_errs = 0;
      for (int i = 0; i < (1 << WA_W); i++) begin
         mem[i]    = fill_word(WA_W'(i));
         shadow[i] = fill_word(WA_W'(i));
      end
      repeat (RESET_CYC) @(posedge i_clk);
      i_rst <= 1'b0;

      // Quiet outputs right after reset
      // Readies follow one cycle later
      @(negedge i_clk);
      check_bit("o_awready", o_awready, 1'b0);
      check_bit("o_wready", o_wready, 1'b0);
      check_bit("o_arready", o_arready, 1'b0);
      check_bit("o_bvalid", o_bvalid, 1'b0);
      check_bit("o_rvalid", o_rvalid, 1'b0);
      check_bit("o_wb_req.stb", o_wb_req.stb, 1'b0);
      check_bit("o_wb_req.we", o_wb_req.we, 1'b0);
      @(posedge i_clk);
      @(negedge i_clk);
      check_bit("o_awready", o_awready, 1'b1);
      check_bit("o_wready", o_wready, 1'b1);
      check_bit("o_arready", o_arready, 1'b1);

      for (int k = 0; k < 4; k++) write_then_read(rand_addr(2'b00), 0, 0);

      // AW and W skewed both ways
      for (int k = 0; k < 4; k++) begin
         write_then_read(rand_addr(2'b00), (k % 2) ? 5 : 0, (k % 2) ? 0 : 5);
      end

      bp_en = 1'b1;
      for (int k = 0; k < 6; k++) begin
         do_write(rand_addr(2'b00), rand_bits(32), 4'(rand_bits(4)), 0, 0);
      end
      wait_idle();
      for (int k = 0; k < 6; k++) do_read(rand_addr(2'b00), 0);
      wait_idle();
      bp_en = 1'b0;

      // Writes in the low quarter and reads in the next one
      // Both streams stay in flight together
      fork
         for (int k = 0; k < N_CONC; k++) begin
            do_write(rand_addr(2'b00), rand_bits(32), 4'(rand_bits(4)),
                     rand_bits(2), rand_bits(2));
         end
         for (int k = 0; k < N_CONC; k++) do_read(rand_addr(2'b01), rand_bits(2));
      join
      wait_idle();

      write_then_read(rand_addr(2'b10), 0, 0);
      write_then_read(rand_addr(2'b11), 2, 0);

      repeat (4) @(posedge i_clk);
      $display("Errors: b=%0d r=%0d signal=%0d protocol=%0d",
               b_errs, r_errs, sig_errs, other_errs);
      if (b_errs + r_errs + sig_errs + other_errs == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/axi_lite_pkg.sv
design/wb_pkg.sv
design/axi_chan_slot.sv
design/axi_wb_sequencer.sv
design/axi_wb_bridge_top.sv
dv/tb_axi_wb_bridge.sv
